// ==== design/dcache_pkg.sv ====
// Data cache shared definitions
// Cache geometry, CPU and bus request and response structs, and the
// helpers that split a byte address into tag, set index and word fields.
// A line is 32 bytes: bits 4..2 pick the word, bit 4 alone picks the
// half-line that travels as one bus beat.

`default_nettype none

package dcache_pkg;

	// ========================================================================
	// Geometry
	// ========================================================================
	localparam int WAYS      = 4;
	localparam int SETS      = 16;
	localparam int LINE_BITS = 256;
	localparam int BUS_BITS  = 128;
	localparam int WORD_BITS = 32;
	localparam int ADR_BITS  = 32;
	localparam int LFSR_BITS = 17;

	localparam int WAY_BITS  = $clog2(WAYS);
	localparam int SEL_BITS  = BUS_BITS / WORD_BITS;

	// Address field positions
	localparam int LANE_LO       = 2;
	localparam int LANE_BITS     = $clog2(SEL_BITS);
	localparam int BEAT_BIT      = LANE_LO + LANE_BITS;
	localparam int WORD_SEL_BITS = $clog2(LINE_BITS / WORD_BITS);
	localparam int INDEX_LO      = LANE_LO + WORD_SEL_BITS;
	localparam int INDEX_BITS    = $clog2(SETS);
	localparam int TAG_LO        = INDEX_LO + INDEX_BITS;
	localparam int TAG_BITS      = ADR_BITS - TAG_LO;
	// Addresses in the upper half of the map bypass the cache
	localparam int NC_BIT        = ADR_BITS - 1;

	typedef logic [WAY_BITS-1:0]   way_t;
	typedef logic [LINE_BITS-1:0]  line_t;
	typedef logic [TAG_BITS-1:0]   tag_t;
	typedef logic [INDEX_BITS-1:0] idx_t;

	// ========================================================================
	// Port structs
	// ========================================================================
	typedef struct packed {
		logic                 we;
		logic [ADR_BITS-1:0]  adr;
		logic [WORD_BITS-1:0] dat;
	} cpu_req_t;

	typedef struct packed {
		logic                 valid;
		logic                 err;
		logic [WORD_BITS-1:0] dat;
	} cpu_resp_t;

	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [SEL_BITS-1:0] sel;
		logic [ADR_BITS-1:0] adr;
		logic [BUS_BITS-1:0] dat;
	} bus_req_t;

	typedef struct packed {
		logic                ack;
		logic                err;
		logic [BUS_BITS-1:0] dat;
	} bus_resp_t;

	// ========================================================================
	// Address helpers
	// ========================================================================
	function automatic idx_t idx_of(input logic [ADR_BITS-1:0] adr);
		return adr[INDEX_LO +: INDEX_BITS];
	endfunction

	function automatic tag_t tag_of(input logic [ADR_BITS-1:0] adr);
		return adr[TAG_LO +: TAG_BITS];
	endfunction

	function automatic logic [WORD_SEL_BITS-1:0] word_of(input logic [ADR_BITS-1:0] adr);
		return adr[LANE_LO +: WORD_SEL_BITS];
	endfunction

	// Word lane inside one bus beat
	function automatic logic [LANE_BITS-1:0] lane_of(input logic [ADR_BITS-1:0] adr);
		return adr[LANE_LO +: LANE_BITS];
	endfunction

	// Bus address of one half-line, beat aligned
	function automatic logic [ADR_BITS-1:0] beat_adr(input tag_t tag, input idx_t idx,
		input logic beat);
		return {tag, idx, beat, {BEAT_BIT{1'b0}}};
	endfunction

endpackage

`default_nettype wire

// ==== design/dcache_lfsr.sv ====
// Replacement LFSR
// Maximal-length 17-bit Fibonacci LFSR (x^17 + x^14 + 1) that steps on
// every clock. Its low bits pick the victim way on a miss.

`timescale 1ns/1ps
`default_nettype none

module dcache_lfsr (
	input  wire                             clk_i,
	input  wire                             rst_i,
	output logic [dcache_pkg::LFSR_BITS-1:0] lfsr_o
);

	import dcache_pkg::*;

	logic feedback;

	// Taps at stages 17 and 14 give the full 2^17-1 period
	assign feedback = lfsr_o[LFSR_BITS-1] ^ lfsr_o[LFSR_BITS-4];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			// All zeros is the lock-up state so the seed must be nonzero
			lfsr_o <= {{(LFSR_BITS-1){1'b0}}, 1'b1};
		end else begin
			lfsr_o <= {lfsr_o[LFSR_BITS-2:0], feedback};
		end
	end

endmodule

`default_nettype wire

// ==== design/dcache_array.sv ====
// Data cache storage arrays
// Holds tag, valid, dirty and line data for every way and set. A lookup
// registers the tag compare over all ways together with the addressed word,
// and also registers the state of the proposed victim way. A fill writes a
// whole line at the set and tag of the last lookup. A word write updates one
// word and marks the line dirty.

`timescale 1ns/1ps
`default_nettype none

module dcache_array (
	input  wire                                clk_i,
	input  wire                                rst_i,
	input  wire                                lookup_i,
	input  wire [dcache_pkg::ADR_BITS-1:0]     lookup_adr_i,
	output logic                               hit_o,
	output dcache_pkg::way_t                   hit_way_o,
	output logic [dcache_pkg::WORD_BITS-1:0]   rd_word_o,
	input  wire dcache_pkg::way_t              victim_way_i,
	output logic                               victim_dirty_o,
	output dcache_pkg::tag_t                   victim_tag_o,
	output dcache_pkg::line_t                  victim_line_o,
	input  wire                                fill_i,
	input  wire dcache_pkg::way_t              fill_way_i,
	input  wire dcache_pkg::line_t             fill_line_i,
	input  wire                                wr_word_i,
	input  wire dcache_pkg::way_t              wr_way_i,
	input  wire [dcache_pkg::ADR_BITS-1:0]     wr_adr_i,
	input  wire [dcache_pkg::WORD_BITS-1:0]    wr_dat_i
);

	import dcache_pkg::*;

	// ========================================================================
	// Storage
	// ========================================================================
	tag_t  tag_mem  [WAYS][SETS];
	line_t data_mem [WAYS][SETS];

	// One valid and one dirty bit per line
	logic [WAYS-1:0][SETS-1:0] valid_q;
	logic [WAYS-1:0][SETS-1:0] dirty_q;

	// The set and tag of the last lookup, which a later fill writes to
	logic [ADR_BITS-1:0] lookup_adr_q;

	idx_t lk_idx;
	tag_t lk_tag;
	logic match;
	way_t match_way;

	// ========================================================================
	// Tag compare across all ways
	// ========================================================================
	always_comb begin
		lk_idx    = idx_of(lookup_adr_i);
		lk_tag    = tag_of(lookup_adr_i);
		match     = 1'b0;
		match_way = '0;
		// Only one way can match since a line is filled only after a miss
		for (int w = 0; w < WAYS; w++) begin
			if (valid_q[w][lk_idx] && tag_mem[w][lk_idx] == lk_tag) begin
				match     = 1'b1;
				match_way = way_t'(w);
			end
		end
	end

	// Hit flag and victim dirty flag steer the controller after reset
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			hit_o          <= 1'b0;
			victim_dirty_o <= 1'b0;
		end else if (lookup_i) begin
			hit_o          <= match;
			// An invalid victim never needs a write-back
			victim_dirty_o <= valid_q[victim_way_i][lk_idx] & dirty_q[victim_way_i][lk_idx];
		end
	end

	always_ff @(posedge clk_i) begin
		if (lookup_i) begin
			lookup_adr_q  <= lookup_adr_i;
			hit_way_o     <= match_way;
			rd_word_o     <= data_mem[match_way][lk_idx][word_of(lookup_adr_i)*WORD_BITS +:
				WORD_BITS];
			victim_tag_o  <= tag_mem[victim_way_i][lk_idx];
			victim_line_o <= data_mem[victim_way_i][lk_idx];
		end
	end

	// ========================================================================
	// Line fill and word write
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (fill_i) begin
			tag_mem[fill_way_i][idx_of(lookup_adr_q)]  <= tag_of(lookup_adr_q);
			data_mem[fill_way_i][idx_of(lookup_adr_q)] <= fill_line_i;
		end else if (wr_word_i) begin
			data_mem[wr_way_i][idx_of(wr_adr_i)][word_of(wr_adr_i)*WORD_BITS +: WORD_BITS]
				<= wr_dat_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (fill_i) begin
			// Freshly loaded lines match memory
			valid_q[fill_way_i][idx_of(lookup_adr_q)] <= 1'b1;
			dirty_q[fill_way_i][idx_of(lookup_adr_q)] <= 1'b0;
		end else if (wr_word_i) begin
			dirty_q[wr_way_i][idx_of(wr_adr_i)] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/dcache_miss_ctrl.sv ====
// Data cache controller
// Accepts one CPU request at a time. Cacheable requests do a lookup and a
// hit is answered on the next cycle. A miss writes back a dirty victim in
// two store beats, loads the new line in two read beats, fills it and then
// merges store data. Non-cacheable requests make one single-word bus beat.
// A bus error ends the request with the error flag and no array update.

`timescale 1ns/1ps
`default_nettype none

module dcache_miss_ctrl (
	input  wire                               clk_i,
	input  wire                               rst_i,
	input  wire                               cpu_req_valid_i,
	input  wire dcache_pkg::cpu_req_t         cpu_req_i,
	output dcache_pkg::cpu_resp_t             cpu_resp_o,
	output dcache_pkg::bus_req_t              bus_req_o,
	input  wire dcache_pkg::bus_resp_t        bus_resp_i,
	input  wire [dcache_pkg::LFSR_BITS-1:0]   lfsr_i,
	output logic                              lookup_o,
	output logic [dcache_pkg::ADR_BITS-1:0]   lookup_adr_o,
	input  wire                               hit_i,
	input  wire dcache_pkg::way_t             hit_way_i,
	input  wire [dcache_pkg::WORD_BITS-1:0]   rd_word_i,
	output dcache_pkg::way_t                  victim_way_o,
	input  wire                               victim_dirty_i,
	input  wire dcache_pkg::tag_t             victim_tag_i,
	input  wire dcache_pkg::line_t            victim_line_i,
	output logic                              fill_o,
	output dcache_pkg::way_t                  fill_way_o,
	output dcache_pkg::line_t                 fill_line_o,
	output logic                              wr_word_o,
	output dcache_pkg::way_t                  wr_way_o,
	output logic [dcache_pkg::ADR_BITS-1:0]   wr_adr_o,
	output logic [dcache_pkg::WORD_BITS-1:0]  wr_dat_o
);

	import dcache_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_WB,
		S_RD,
		S_FILL,
		S_DONE,
		S_NC
	} state_t;

	state_t   state_q;
	cpu_req_t req_q;
	way_t     vway_q;
	line_t    line_q;
	// Current half-line, it becomes address bit 4 of each beat
	logic     beat_q;

	logic bus_done;
	logic bus_fail;
	logic [LANE_BITS-1:0] lane;

	// A beat finishes on the first cycle with ack or err while cyc is up
	assign bus_done = bus_req_o.cyc & bus_resp_i.ack & ~bus_resp_i.err;
	assign bus_fail = bus_req_o.cyc & bus_resp_i.err;
	assign lane     = lane_of(req_q.adr);

	// ========================================================================
	// Array commands
	// ========================================================================
	always_comb begin
		// The lookup is launched straight from the request strobe
		lookup_o     = (state_q == S_IDLE) && cpu_req_valid_i && !cpu_req_i.adr[NC_BIT];
		lookup_adr_o = cpu_req_i.adr;
		// The array samples the victim in the same cycle that vway_q captures it
		victim_way_o = lfsr_i[WAY_BITS-1:0];
		fill_o       = (state_q == S_FILL);
		fill_way_o   = vway_q;
		fill_line_o  = line_q;
		// Store data lands on a hit or right after the fill of a store miss
		wr_word_o    = req_q.we && ((state_q == S_LOOKUP && hit_i) || state_q == S_DONE);
		wr_way_o     = (state_q == S_DONE) ? vway_q : hit_way_i;
		wr_adr_o     = req_q.adr;
		wr_dat_o     = req_q.dat;
	end

	// Request, victim way and line buffer
	always_ff @(posedge clk_i) begin
		if (state_q == S_IDLE && cpu_req_valid_i) begin
			req_q  <= cpu_req_i;
			vway_q <= lfsr_i[WAY_BITS-1:0];
		end
		if (state_q == S_RD && bus_done) begin
			line_q[beat_q*BUS_BITS +: BUS_BITS] <= bus_resp_i.dat;
		end
	end

	// ========================================================================
	// Request FSM and bus master
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q    <= S_IDLE;
			beat_q     <= 1'b0;
			bus_req_o  <= '0;
			cpu_resp_o <= '0;
		end else begin
			cpu_resp_o.valid <= 1'b0;
			// Drop the strobes one cycle after the beat ends
			if (bus_done || bus_fail) begin
				bus_req_o.cyc <= 1'b0;
				bus_req_o.stb <= 1'b0;
			end
			if (bus_fail) begin
				// Abandon the request, nothing was written to the arrays
				cpu_resp_o.valid <= 1'b1;
				cpu_resp_o.err   <= 1'b1;
				cpu_resp_o.dat   <= '0;
				beat_q           <= 1'b0;
				state_q          <= S_IDLE;
			end else begin
				case (state_q)
				S_IDLE: begin
					if (cpu_req_valid_i) begin
						beat_q  <= 1'b0;
						state_q <= cpu_req_i.adr[NC_BIT] ? S_NC : S_LOOKUP;
					end
				end
				S_LOOKUP: begin
					if (hit_i) begin
						cpu_resp_o.valid <= 1'b1;
						cpu_resp_o.err   <= 1'b0;
						cpu_resp_o.dat   <= rd_word_i;
						state_q          <= S_IDLE;
					end else begin
						state_q <= victim_dirty_i ? S_WB : S_RD;
					end
				end
				// Store the dirty victim back at its old tag address
				S_WB: begin
					if (!bus_req_o.cyc) begin
						bus_req_o <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1,
							sel: {SEL_BITS{1'b1}},
							adr: beat_adr(victim_tag_i, idx_of(req_q.adr), beat_q),
							dat: victim_line_i[beat_q*BUS_BITS +: BUS_BITS]};
					end else if (bus_done) begin
						beat_q <= ~beat_q;
						if (beat_q)
							state_q <= S_RD;
					end
				end
				// Load the new line half by half
				S_RD: begin
					if (!bus_req_o.cyc) begin
						bus_req_o <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0,
							sel: {SEL_BITS{1'b1}},
							adr: beat_adr(tag_of(req_q.adr), idx_of(req_q.adr), beat_q),
							dat: '0};
					end else if (bus_done) begin
						beat_q <= ~beat_q;
						if (beat_q)
							state_q <= S_FILL;
					end
				end
				S_FILL: begin
					state_q <= S_DONE;
				end
				S_DONE: begin
					cpu_resp_o.valid <= 1'b1;
					cpu_resp_o.err   <= 1'b0;
					cpu_resp_o.dat   <= line_q[word_of(req_q.adr)*WORD_BITS +: WORD_BITS];
					state_q          <= S_IDLE;
				end
				// Single word beat, store data is copied to every lane
				S_NC: begin
					if (!bus_req_o.cyc) begin
						bus_req_o <= '{cyc: 1'b1, stb: 1'b1, we: req_q.we,
							sel: SEL_BITS'(1) << lane,
							adr: {req_q.adr[ADR_BITS-1:BEAT_BIT], {BEAT_BIT{1'b0}}},
							dat: {SEL_BITS{req_q.dat}}};
					end else if (bus_done) begin
						cpu_resp_o.valid <= 1'b1;
						cpu_resp_o.err   <= 1'b0;
						cpu_resp_o.dat   <= bus_resp_i.dat[lane*WORD_BITS +: WORD_BITS];
						state_q          <= S_IDLE;
					end
				end
				default: begin
					state_q <= S_IDLE;
				end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
// Data cache top level
// Ties the storage arrays, the controller and the replacement LFSR together
// and presents the CPU request port and the bus master port.

`timescale 1ns/1ps
`default_nettype none

module dcache_top (
	input  wire                         clk_i,
	input  wire                         rst_i,
	input  wire                         cpu_req_valid_i,
	input  wire dcache_pkg::cpu_req_t   cpu_req_i,
	output dcache_pkg::cpu_resp_t       cpu_resp_o,
	output dcache_pkg::bus_req_t        bus_req_o,
	input  wire dcache_pkg::bus_resp_t  bus_resp_i
);

	import dcache_pkg::*;

	logic [LFSR_BITS-1:0] lfsr;

	// Lookup path
	logic                 lookup;
	logic [ADR_BITS-1:0]  lookup_adr;
	logic                 hit;
	way_t                 hit_way;
	logic [WORD_BITS-1:0] rd_word;

	// Victim state registered with the lookup
	way_t                 victim_way;
	logic                 victim_dirty;
	tag_t                 victim_tag;
	line_t                victim_line;

	// Write ports
	logic                 fill;
	way_t                 fill_way;
	line_t                fill_line;
	logic                 wr_word;
	way_t                 wr_way;
	logic [ADR_BITS-1:0]  wr_adr;
	logic [WORD_BITS-1:0] wr_dat;

	dcache_lfsr i_dcache_lfsr (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.lfsr_o (lfsr)
	);

	dcache_array i_dcache_array (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.lookup_i       (lookup),
		.lookup_adr_i   (lookup_adr),
		.hit_o          (hit),
		.hit_way_o      (hit_way),
		.rd_word_o      (rd_word),
		.victim_way_i   (victim_way),
		.victim_dirty_o (victim_dirty),
		.victim_tag_o   (victim_tag),
		.victim_line_o  (victim_line),
		.fill_i         (fill),
		.fill_way_i     (fill_way),
		.fill_line_i    (fill_line),
		.wr_word_i      (wr_word),
		.wr_way_i       (wr_way),
		.wr_adr_i       (wr_adr),
		.wr_dat_i       (wr_dat)
	);

	dcache_miss_ctrl i_dcache_miss_ctrl (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.cpu_req_valid_i (cpu_req_valid_i),
		.cpu_req_i       (cpu_req_i),
		.cpu_resp_o      (cpu_resp_o),
		.bus_req_o       (bus_req_o),
		.bus_resp_i      (bus_resp_i),
		.lfsr_i          (lfsr),
		.lookup_o        (lookup),
		.lookup_adr_o    (lookup_adr),
		.hit_i           (hit),
		.hit_way_i       (hit_way),
		.rd_word_i       (rd_word),
		.victim_way_o    (victim_way),
		.victim_dirty_i  (victim_dirty),
		.victim_tag_i    (victim_tag),
		.victim_line_i   (victim_line),
		.fill_o          (fill),
		.fill_way_o      (fill_way),
		.fill_line_o     (fill_line),
		.wr_word_o       (wr_word),
		.wr_way_o        (wr_way),
		.wr_adr_o        (wr_adr),
		.wr_dat_o        (wr_dat)
	);

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
// Testbench clock and reset
// Makes an 8 ns clock and holds the synchronous reset high for the first
// 16 rising edges.

`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	output logic clk_o,
	output logic rst_o
);

	localparam int HALF_PERIOD_NS = 4;
	localparam int RESET_CYCLES   = 16;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== bench/mem_model.sv ====
// Bus memory model
// Answers each cyc/stb beat from a sparse word memory after a random delay
// of one to four cycles. Beats inside a fixed address window get err.

`timescale 1ns/1ps
`default_nettype none

module mem_model (
	input  wire                        clk_i,
	input  wire                        rst_i,
	input  wire dcache_pkg::bus_req_t  bus_req_i,
	output dcache_pkg::bus_resp_t      bus_resp_o
);

	import dcache_pkg::*;

	localparam logic [ADR_BITS-1:0] ERR_LO   = 32'h0000_f000;
	localparam logic [ADR_BITS-1:0] ERR_HI   = 32'h0000_ffff;
	localparam logic [31:0]         INIT_XOR = 32'h5a5a5a5a;

	// Only words that were stored live here, all others follow the pattern
	logic [31:0] mem_q [logic [31:0]];

	bus_resp_t  resp_q    = '0;
	logic       pending_q = 1'b0;
	logic [1:0] wait_q    = 2'd0;

	assign bus_resp_o = resp_q;

	function automatic logic [31:0] read_word(input logic [31:0] adr);
		if (mem_q.exists(adr))
			return mem_q[adr];
		return adr ^ INIT_XOR;
	endfunction

	// ========================================================================
	// Beat responder
	// ========================================================================
	always @(posedge clk_i) begin : respond
		logic [31:0]         lane_adr;
		logic [BUS_BITS-1:0] rd_beat;
		if (rst_i) begin
			resp_q    <= '0;
			pending_q <= 1'b0;
			wait_q    <= 2'd0;
		end else begin
			// Ack and err are single-cycle pulses
			resp_q.ack <= 1'b0;
			resp_q.err <= 1'b0;
			if (pending_q) begin
				if (wait_q != 2'd0) begin
					wait_q <= wait_q - 2'd1;
				end else begin
					pending_q <= 1'b0;
					if (bus_req_i.adr >= ERR_LO && bus_req_i.adr <= ERR_HI) begin
						resp_q.err <= 1'b1;
						resp_q.dat <= '0;
					end else begin
						rd_beat = '0;
						// Lane i of the beat is the word at beat address plus 4*i
						for (int i = 0; i < SEL_BITS; i++) begin
							lane_adr = bus_req_i.adr + 32'(i * 4);
							if (bus_req_i.we && bus_req_i.sel[i])
								mem_q[lane_adr] = bus_req_i.dat[i*WORD_BITS +: WORD_BITS];
							rd_beat[i*WORD_BITS +: WORD_BITS] = read_word(lane_adr);
						end
						resp_q.ack <= 1'b1;
						resp_q.dat <= bus_req_i.we ? '0 : rd_beat;
					end
				end
			end else if (bus_req_i.cyc && bus_req_i.stb && !resp_q.ack && !resp_q.err) begin
				// The master still holds cyc in the cycle after a response, so skip it
				pending_q <= 1'b1;
				wait_q    <= 2'($urandom_range(3, 0));
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/dcache_tb.sv ====
// Data cache testbench
// Drives directed loads and stores into the cache, with a bus memory model
// behind it, and compares every load with a shadow copy of memory that is
// built from the same initial pattern and the stores that succeeded.

`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

	import dcache_pkg::*;

	localparam int          CLK_PERIOD_NS = 8;
	localparam int          RESET_CYCLES  = 16;
	localparam int          NUM_REQUESTS  = 221;
	// Worst-case dirty miss is four beats of up to six cycles plus overhead
	localparam int          MISS_CYCLES   = 4 * 6 + 10;
	localparam int          WATCHDOG_NS   =
		(RESET_CYCLES + NUM_REQUESTS * MISS_CYCLES) * CLK_PERIOD_NS;
	localparam int          REQ_LIMIT     = 2 * MISS_CYCLES;
	localparam int          RANDOM_OPS    = 200;
	localparam logic [31:0] RANDOM_SEED   = 32'h1694690d;
	localparam logic [31:0] INIT_XOR      = 32'h5a5a5a5a;

	logic      clk;
	logic      rst;
	logic      cpu_req_valid;
	cpu_req_t  cpu_req;
	cpu_resp_t cpu_resp;
	bus_req_t  bus_req;
	bus_resp_t bus_resp;

	// Shadow of memory as the CPU should see it
	logic [31:0] shadow [logic [31:0]];

	clk_gen i_clk_gen (
		.clk_o (clk),
		.rst_o (rst)
	);

	dcache_top i_dcache_top (
		.clk_i           (clk),
		.rst_i           (rst),
		.cpu_req_valid_i (cpu_req_valid),
		.cpu_req_i       (cpu_req),
		.cpu_resp_o      (cpu_resp),
		.bus_req_o       (bus_req),
		.bus_resp_i      (bus_resp)
	);

	mem_model i_mem_model (
		.clk_i      (clk),
		.rst_i      (rst),
		.bus_req_i  (bus_req),
		.bus_resp_o (bus_resp)
	);

	// ========================================================================
	// Shadow memory, checks and request driver
	// ========================================================================
	function automatic logic [31:0] shadow_read(input logic [31:0] adr);
		if (shadow.exists(adr))
			return shadow[adr];
		return adr ^ INIT_XOR;
	endfunction

	task automatic end_with_failure();
		$display("Checks failed");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s expected 0x%08h got 0x%08h", name, expected, actual);
			end_with_failure();
		end
	endtask

	// Pulses one request and samples the response strobe at each negedge
	task automatic issue_request(input logic we, input logic [31:0] adr,
		input logic [31:0] dat, output cpu_resp_t resp, output int cycles);
		@(posedge clk);
		cpu_req_valid <= 1'b1;
		cpu_req       <= '{we: we, adr: adr, dat: dat};
		cycles = 0;
		resp   = '0;
		while (!resp.valid) begin
			@(posedge clk);
			cpu_req_valid <= 1'b0;
			@(negedge clk);
			cycles++;
			resp = cpu_resp;
			if (!resp.valid && cycles > REQ_LIMIT) begin
				$display("Request to 0x%08h got no response within %0d cycles",
					adr, REQ_LIMIT);
				end_with_failure();
			end
		end
	endtask

	task automatic load_and_check(input logic [31:0] adr, output int cycles);
		cpu_resp_t resp;
		issue_request(1'b0, adr, '0, resp, cycles);
		check_value($sformatf("cpu_resp_o.err for load 0x%08h", adr), 32'd0, 32'(resp.err));
		check_value($sformatf("cpu_resp_o.dat for load 0x%08h", adr), shadow_read(adr),
			resp.dat);
	endtask

	task automatic store_word(input logic [31:0] adr, input logic [31:0] dat,
		output int cycles);
		cpu_resp_t resp;
		issue_request(1'b1, adr, dat, resp, cycles);
		check_value($sformatf("cpu_resp_o.err for store 0x%08h", adr), 32'd0, 32'(resp.err));
		shadow[adr] = dat;
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================
	task automatic read_miss_fill();
		int cycles;
		load_and_check(32'h0000_1040, cycles);
		// Another word of the line just filled hits in two cycles
		load_and_check(32'h0000_105c, cycles);
		check_value("cpu_resp_o.valid latency of load hit", 32'd2, 32'(cycles));
	endtask

	task automatic store_hit_reload();
		int cycles;
		store_word(32'h0000_1048, 32'hdead_beef, cycles);
		check_value("cpu_resp_o.valid latency of store hit", 32'd2, 32'(cycles));
		load_and_check(32'h0000_1048, cycles);
		load_and_check(32'h0000_104c, cycles);
	endtask

	// Five tags in set 3 overflow the four ways and force dirty evictions
	task automatic dirty_writeback();
		int cycles;
		for (int k = 0; k < 5; k++)
			store_word(32'h0000_2064 + 32'(k * 512), 32'hc0de_0000 + 32'(k), cycles);
		for (int k = 0; k < 5; k++)
			load_and_check(32'h0000_2064 + 32'(k * 512), cycles);
	endtask

	task automatic noncacheable_access();
		int cycles;
		store_word(32'h8000_0124, 32'h1234_5678, cycles);
		load_and_check(32'h8000_0124, cycles);
		// The single sel bit must leave the next lane of the beat alone
		load_and_check(32'h8000_0128, cycles);
		load_and_check(32'h0000_0124, cycles);
	endtask

	task automatic bus_error();
		cpu_resp_t resp;
		int        cycles;
		issue_request(1'b0, 32'h0000_f010, '0, resp, cycles);
		check_value("cpu_resp_o.err for load 0x0000f010", 32'd1, 32'(resp.err));
		load_and_check(32'h0000_3080, cycles);
	endtask

	// Six tags over sets 0 to 2 so that evictions happen often
	task automatic random_mix();
		logic [31:0] tag_sel;
		logic [31:0] set_sel;
		logic [31:0] word_sel;
		logic [31:0] adr;
		logic [31:0] dat;
		int          cycles;
		for (int n = 0; n < RANDOM_OPS; n++) begin
			tag_sel  = $urandom_range(5, 0);
			set_sel  = $urandom_range(2, 0);
			word_sel = $urandom_range(7, 0);
			dat      = $urandom();
			adr      = 32'h0000_4000 + (tag_sel << 9) + (set_sel << 5) + (word_sel << 2);
			if ($urandom_range(1, 0) == 1)
				store_word(adr, dat, cycles);
			else
				load_and_check(adr, cycles);
		end
	endtask

	// ========================================================================
	// Test sequence and watchdog
	// ========================================================================
	initial begin : main
		cpu_req_valid <= 1'b0;
		cpu_req       <= '0;
		// Seed the random stream once before any test draws from it
		void'($urandom(RANDOM_SEED));
		@(negedge rst);
		read_miss_fill();
		store_hit_reload();
		dirty_writeback();
		noncacheable_access();
		bus_error();
		random_mix();
		$display("All checks passed");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
		end_with_failure();
	end

endmodule

`default_nettype wire

// ==== compile.f ====
design/dcache_pkg.sv
design/dcache_lfsr.sv
design/dcache_array.sv
design/dcache_miss_ctrl.sv
design/dcache_top.sv
bench/clk_gen.sv
bench/mem_model.sv
bench/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the data cache testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the run ends in $fatal.
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module dcache_tb -Mdir obj_dir -f compile.f &&
./obj_dir/Vdcache_tb ||
{ echo "Simulation did not pass"; exit 1; }
